// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = tb_apu_subsys
FILELIST = list.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = TB PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== hw/apu_cfg_pkg.sv ====
/*
 * APU configuration
 * Data and address widths, operand count, latency classes and divider
 * length, shared by the dispatcher and the APU model
 */

package apu_cfg_pkg;

  // Datapath
  localparam int unsigned APU_DW    = 32;
  localparam int unsigned APU_NARGS = 3;

  // Register file address width on the core side
  localparam int unsigned APU_AW    = 6;

  // Latency class encoding
  localparam int unsigned APU_LAT_W = 2;

  // Restoring divider, one quotient bit per cycle
  localparam int unsigned DIV_STEPS = 32;
  localparam int unsigned DIV_CNT_W = $clog2(DIV_STEPS);

  typedef logic [APU_DW-1:0]    apu_word_t;
  typedef logic [APU_AW-1:0]    apu_addr_t;
  typedef logic [APU_LAT_W-1:0] apu_lat_t;

  // Class 0 returns in the grant cycle, 1 and 2 after that many stages
  localparam apu_lat_t LAT_COMB  = 2'd0;
  localparam apu_lat_t LAT_PIPE1 = 2'd1;
  localparam apu_lat_t LAT_PIPE2 = 2'd2;
  // Variable length, blocks the unit while it runs
  localparam apu_lat_t LAT_ITER  = 2'd3;

endpackage

// ==== hw/apu_disp.sv ====
/*
 * APU dispatcher
 * Issues core instructions to the APU, tracks up to two unreturned
 * results, flags register dependencies and stalls the core
 */

`timescale 1ns/100ps

module apu_disp (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,

  // Instruction from the core
  input  logic                                       enable_i,
  input  apu_op_pkg::apu_op_t                        op_i,
  input  apu_cfg_pkg::apu_word_t [apu_cfg_pkg::APU_NARGS-1:0] operands_i,
  input  apu_cfg_pkg::apu_addr_t                     waddr_i,

  // Write back
  output logic                                       valid_o,
  output apu_cfg_pkg::apu_addr_t                     waddr_o,
  output logic                                       multicycle_o,

  // Status and stall
  output logic                                       active_o,
  output logic                                       stall_o,

  // Dependency checks
  input  apu_cfg_pkg::apu_addr_t [2:0]               read_regs_i,
  input  logic [2:0]                                 read_regs_valid_i,
  output logic                                       read_dep_o,
  input  apu_cfg_pkg::apu_addr_t [1:0]               write_regs_i,
  input  logic [1:0]                                 write_regs_valid_i,
  output logic                                       write_dep_o,

  // Performance events
  output logic                                       perf_type_o,
  output logic                                       perf_cont_o,

  // APU side
  apu_req_if.disp                                    bus
);

  import apu_cfg_pkg::*;
  import apu_op_pkg::*;

  apu_addr_t  addr_req;
  apu_addr_t  addr_inflight;
  apu_addr_t  addr_waiting;
  apu_addr_t  addr_inflight_d;
  apu_addr_t  addr_waiting_d;
  logic       valid_req;
  logic       valid_inflight;
  logic       valid_waiting;
  logic       valid_inflight_d;
  logic       valid_waiting_d;
  logic       returned_req;
  logic       returned_inflight;
  logic       returned_waiting;
  logic       req_accepted;
  logic       active;
  apu_lat_t   lat_new;
  apu_lat_t   lat_q;
  apu_lat_t   lat_diff;
  logic [2:0] read_deps_req;
  logic [2:0] read_deps_inflight;
  logic [2:0] read_deps_waiting;
  logic [1:0] write_deps_req;
  logic [1:0] write_deps_inflight;
  logic [1:0] write_deps_waiting;
  logic       stall_full;
  logic       stall_type;
  logic       stall_nack;

  ////////////////////////////////////////////////////////////////////////////
  // Request
  ////////////////////////////////////////////////////////////////////////////

  // No request under a full or class stall, a refused grant keeps it up
  assign valid_req    = enable_i & ~(stall_full | stall_type);
  assign addr_req     = waddr_i;
  assign req_accepted = valid_req & bus.gnt;

  assign bus.req      = valid_req;
  assign bus.op       = op_i;
  assign bus.operands = operands_i;

  ////////////////////////////////////////////////////////////////////////////
  // Slot tracking
  ////////////////////////////////////////////////////////////////////////////

  // Which instruction does the current valid belong to
  // Waiting holds the older one, so it returns first
  assign returned_req      = valid_req & bus.valid & ~valid_inflight & ~valid_waiting;
  assign returned_inflight = valid_inflight & bus.valid & ~valid_waiting;
  assign returned_waiting  = valid_waiting & bus.valid;

  always_comb begin
    valid_inflight_d = valid_inflight;
    valid_waiting_d  = valid_waiting;
    addr_inflight_d  = addr_inflight;
    addr_waiting_d   = addr_waiting;

    if (req_accepted && !returned_req) begin
      // New multicycle instruction enters the in-flight slot
      valid_inflight_d = 1'b1;
      addr_inflight_d  = addr_req;
      // Older one still pending moves down to waiting
      if ((valid_inflight && !returned_inflight) || returned_waiting) begin
        valid_waiting_d = 1'b1;
        addr_waiting_d  = addr_inflight;
      end
    end else if (returned_inflight) begin
      valid_inflight_d = 1'b0;
    end else if (returned_waiting) begin
      valid_waiting_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_inflight <= 1'b0;
      valid_waiting  <= 1'b0;
    end else begin
      valid_inflight <= valid_inflight_d;
      valid_waiting  <= valid_waiting_d;
    end
  end

  // Addresses only count while their valid bit is set
  always_ff @(posedge clk_i) begin
    addr_inflight <= addr_inflight_d;
    addr_waiting  <= addr_waiting_d;
  end

  assign active = valid_inflight | valid_waiting;

  // Class of the last request put on the bus
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lat_q <= LAT_COMB;
    end else if (valid_req) begin
      lat_q <= lat_new;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Dependency checks
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < 3; i++) begin : g_read_deps
    assign read_deps_req[i]      = read_regs_valid_i[i] & (read_regs_i[i] == addr_req);
    assign read_deps_inflight[i] = read_regs_valid_i[i] & (read_regs_i[i] == addr_inflight);
    assign read_deps_waiting[i]  = read_regs_valid_i[i] & (read_regs_i[i] == addr_waiting);
  end

  for (genvar i = 0; i < 2; i++) begin : g_write_deps
    assign write_deps_req[i]      = write_regs_valid_i[i] & (write_regs_i[i] == addr_req);
    assign write_deps_inflight[i] = write_regs_valid_i[i] & (write_regs_i[i] == addr_inflight);
    assign write_deps_waiting[i]  = write_regs_valid_i[i] & (write_regs_i[i] == addr_waiting);
  end

  // A slot stops counting in the cycle its result is written back
  assign read_dep_o  = (|read_deps_req      & valid_req      & ~returned_req)
                     | (|read_deps_inflight & valid_inflight & ~returned_inflight)
                     | (|read_deps_waiting  & valid_waiting  & ~returned_waiting);
  assign write_dep_o = (|write_deps_req      & valid_req      & ~returned_req)
                     | (|write_deps_inflight & valid_inflight & ~returned_inflight)
                     | (|write_deps_waiting  & valid_waiting  & ~returned_waiting);

  ////////////////////////////////////////////////////////////////////////////
  // Stall generation
  ////////////////////////////////////////////////////////////////////////////

  assign lat_new  = op_latency(op_i);
  assign lat_diff = lat_q - lat_new;

  // Both slots taken
  assign stall_full = valid_inflight & valid_waiting;

  // While active only issue what cannot overtake a pending result
  // Class 1 always, one class below the last one, and the divider
  // An add returns at once, so it waits too unless the grant is refused anyway
  assign stall_type = enable_i & active &
                      ((lat_new == LAT_PIPE1) |
                       (lat_diff == apu_lat_t'(1)) |
                       (lat_new == LAT_ITER) |
                       ((lat_new == LAT_COMB) & bus.gnt));

  // Unit busy, request stays on the bus
  assign stall_nack = valid_req & ~bus.gnt;

  assign stall_o     = stall_full | stall_type | stall_nack;
  assign perf_type_o = stall_type;
  assign perf_cont_o = stall_nack;

  ////////////////////////////////////////////////////////////////////////////
  // Write back
  ////////////////////////////////////////////////////////////////////////////

  assign valid_o = bus.valid;

  // Steer the write address to the slot that returned
  always_comb begin
    waddr_o = '0;
    if (returned_req) begin
      waddr_o = addr_req;
    end
    if (returned_inflight) begin
      waddr_o = addr_inflight;
    end
    if (returned_waiting) begin
      waddr_o = addr_waiting;
    end
  end

  assign active_o     = active;
  assign multicycle_o = (lat_q == LAT_ITER);

  // Every response must map onto a live request or slot
  a_valid_has_owner: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    bus.valid |-> (bus.req | valid_inflight | valid_waiting)
  ) else $error("APU response without a pending instruction");

endmodule

// ==== hw/apu_op_pkg.sv ====
/*
 * APU operations
 * Opcode encoding and the opcode to latency class lookup
 */

package apu_op_pkg;

  import apu_cfg_pkg::*;

  // Operations offered by the unit, all unsigned
  typedef enum logic [1:0] {
    OP_ADD    = 2'd0,
    OP_MUL    = 2'd1,
    OP_MULADD = 2'd2,
    OP_DIV    = 2'd3
  } apu_op_t;

  // Latency class of each opcode
  // Dispatcher and testbench both decide stalls from this
  function automatic apu_lat_t op_latency(apu_op_t op);
    case (op)
      OP_ADD:    return LAT_COMB;
      OP_MUL:    return LAT_PIPE1;
      OP_MULADD: return LAT_PIPE2;
      OP_DIV:    return LAT_ITER;
    endcase
  endfunction

endpackage

// ==== hw/apu_req_if.sv ====
/*
 * APU request interface
 * Request strobe with grant, opcode and operands toward the unit,
 * valid pulse and result back
 */

`timescale 1ns/100ps

interface apu_req_if;

  import apu_cfg_pkg::*;
  import apu_op_pkg::*;

  // Request channel, taken when req and gnt are both high
  logic                          req;
  logic                          gnt;
  apu_op_t                       op;
  apu_word_t [APU_NARGS-1:0]     operands;

  // Response channel, valid is a single cycle pulse
  logic                          valid;
  apu_word_t                     result;

  // Dispatcher side
  modport disp (
    output req, op, operands,
    input  gnt, valid
  );

  // Execution unit side
  modport unit (
    input  req, op, operands,
    output gnt, valid, result
  );

endinterface

// ==== hw/apu_subsys_top.sv ====
/*
 * APU subsystem
 * Dispatcher and APU model joined over the request interface
 */

`timescale 1ns/100ps

module apu_subsys_top (
  input  logic                         clk_i,
  input  logic                         rst_ni,

  // Core instruction
  input  logic                         enable_i,
  input  apu_op_pkg::apu_op_t          op_i,
  input  apu_cfg_pkg::apu_word_t       a_i,
  input  apu_cfg_pkg::apu_word_t       b_i,
  input  apu_cfg_pkg::apu_word_t       c_i,
  input  apu_cfg_pkg::apu_addr_t       waddr_i,

  // Write back
  output logic                         valid_o,
  output apu_cfg_pkg::apu_addr_t       waddr_o,
  output apu_cfg_pkg::apu_word_t       result_o,
  output logic                         multicycle_o,

  // Status and stall
  output logic                         active_o,
  output logic                         stall_o,

  // Dependency checks
  input  apu_cfg_pkg::apu_addr_t [2:0] read_regs_i,
  input  logic [2:0]                   read_regs_valid_i,
  output logic                         read_dep_o,
  input  apu_cfg_pkg::apu_addr_t [1:0] write_regs_i,
  input  logic [1:0]                   write_regs_valid_i,
  output logic                         write_dep_o,

  // Performance events
  output logic                         perf_type_o,
  output logic                         perf_cont_o
);

  apu_req_if apu_bus ();

  // Operand 0 is a, 2 is c
  apu_disp u_disp (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .enable_i           (enable_i),
    .op_i               (op_i),
    .operands_i         ({c_i, b_i, a_i}),
    .waddr_i            (waddr_i),
    .valid_o            (valid_o),
    .waddr_o            (waddr_o),
    .multicycle_o       (multicycle_o),
    .active_o           (active_o),
    .stall_o            (stall_o),
    .read_regs_i        (read_regs_i),
    .read_regs_valid_i  (read_regs_valid_i),
    .read_dep_o         (read_dep_o),
    .write_regs_i       (write_regs_i),
    .write_regs_valid_i (write_regs_valid_i),
    .write_dep_o        (write_dep_o),
    .perf_type_o        (perf_type_o),
    .perf_cont_o        (perf_cont_o),
    .bus                (apu_bus.disp)
  );

  apu_unit u_unit (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .bus    (apu_bus.unit)
  );

  // Result goes straight to the register file write port
  assign result_o = apu_bus.result;

endmodule

// ==== hw/apu_unit.sv ====
/*
 * APU model
 * Combinational add, one stage multiply, two stage multiply-add and a
 * restoring divider that holds off new requests while it runs
 */

`timescale 1ns/100ps

module apu_unit (
  input  logic    clk_i,
  input  logic    rst_ni,
  apu_req_if.unit bus
);

  import apu_cfg_pkg::*;
  import apu_op_pkg::*;

  logic                 take;
  logic                 add_fire;
  logic                 mul_vld;
  apu_word_t            mul_res;
  logic [1:0]           ma_vld;
  apu_word_t            ma_prod;
  apu_word_t            ma_addend;
  apu_word_t            ma_res;
  logic                 div_busy;
  logic                 div_done;
  logic [DIV_CNT_W-1:0] div_cnt;
  apu_word_t            div_rem;
  apu_word_t            div_quo;
  apu_word_t            div_dsr;
  logic [APU_DW:0]      div_trial;

  // Only the divider can refuse a request
  assign bus.gnt  = ~div_busy;
  assign take     = bus.req & bus.gnt;
  assign add_fire = take & (bus.op == OP_ADD);

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline and divider control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mul_vld  <= 1'b0;
      ma_vld   <= '0;
      div_busy <= 1'b0;
      div_done <= 1'b0;
      div_cnt  <= '0;
    end else begin
      mul_vld  <= take & (bus.op == OP_MUL);
      ma_vld   <= {ma_vld[0], take & (bus.op == OP_MULADD)};
      div_done <= 1'b0;
      if (take && bus.op == OP_DIV) begin
        div_busy <= 1'b1;
        div_cnt  <= '0;
      end else if (div_busy) begin
        div_cnt <= div_cnt + 1'b1;
        // Last quotient bit, result shows in the next cycle
        if (div_cnt == DIV_CNT_W'(DIV_STEPS - 1)) begin
          div_busy <= 1'b0;
          div_done <= 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  // Shifted partial remainder minus divisor, MSB set means it went negative
  assign div_trial = {div_rem, div_quo[APU_DW-1]} - {1'b0, div_dsr};

  always_ff @(posedge clk_i) begin
    // Multiply, one stage
    mul_res   <= bus.operands[0] * bus.operands[1];
    // Multiply-add, product first, then the addend
    ma_prod   <= bus.operands[0] * bus.operands[1];
    ma_addend <= bus.operands[2];
    ma_res    <= ma_prod + ma_addend;

    // Restoring division
    // A zero divisor never borrows, so the quotient ends up all ones
    if (take && bus.op == OP_DIV) begin
      div_rem <= '0;
      div_quo <= bus.operands[0];
      div_dsr <= bus.operands[1];
    end else if (div_busy) begin
      if (!div_trial[APU_DW]) begin
        div_rem <= div_trial[APU_DW-1:0];
        div_quo <= {div_quo[APU_DW-2:0], 1'b1};
      end else begin
        div_rem <= {div_rem[APU_DW-2:0], div_quo[APU_DW-1]};
        div_quo <= {div_quo[APU_DW-2:0], 1'b0};
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response
  ////////////////////////////////////////////////////////////////////////////

  assign bus.valid = add_fire | mul_vld | ma_vld[1] | div_done;

  always_comb begin
    bus.result = '0;
    if (add_fire) begin
      bus.result = bus.operands[0] + bus.operands[1];
    end else if (mul_vld) begin
      bus.result = mul_res;
    end else if (ma_vld[1]) begin
      bus.result = ma_res;
    end else if (div_done) begin
      bus.result = div_quo;
    end
  end

  // Dispatcher stall rule keeps result sources apart
  a_one_result: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $onehot0({add_fire, mul_vld, ma_vld[1], div_done})
  ) else $error("APU result sources collide");

  // Divider result lands DIV_STEPS + 1 cycles after its grant
  a_div_latency: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    div_done |-> $past(take && bus.op == OP_DIV, DIV_STEPS + 1)
  ) else $error("APU divider result at the wrong cycle");

endmodule

// ==== list.f ====
hw/apu_cfg_pkg.sv
hw/apu_op_pkg.sv
hw/apu_req_if.sv
hw/apu_disp.sv
hw/apu_unit.sv
hw/apu_subsys_top.sv
tb/tb_apu_subsys.sv

// ==== tb/apu_patterns.txt ====
// op(0 add,1 mul,2 muladd,3 div) a b c waddr expected gap
// gap is idle cycles after the instruction is accepted
0 00000003 00000004 00000000 01 00000007 1
0 ffffffff 00000001 00000000 02 00000000 0
1 00000006 00000007 00000000 03 0000002a 0
2 00000003 00000005 00000002 04 00000011 0
1 00000002 00000008 00000000 05 00000010 0
2 00000010 00000010 00000001 06 00000101 0
2 00000002 00000003 00000004 07 0000000a 0
3 00000064 00000007 00000000 08 0000000e 0
0 00000005 00000005 00000000 09 0000000a 2
3 0000000a 00000000 00000000 0a ffffffff 0
1 00010000 00010000 00000000 0b 00000000 1
3 ffffffff 00000010 00000000 0c 0fffffff 3
2 ffffffff ffffffff 00000005 0d 00000006 0
1 12345678 00000002 00000000 0e 2468acf0 0
0 12345678 11111111 00000000 0f 23456789 0
3 00000007 00000064 00000000 10 00000000 0
2 00000000 12345678 abcdef01 11 abcdef01 0
1 0000ffff 0000ffff 00000000 12 fffe0001 0
2 0000000c 0000000c 00000000 13 00000090 0
3 deadbeef deadbeef 00000000 14 00000001 0
0 80000000 80000000 00000000 15 00000000 0
1 00000003 00000003 00000000 16 00000009 0
1 00000004 00000004 00000000 17 00000010 0
2 00000001 00000001 00000001 18 00000002 0
3 000003e8 0000000a 00000000 19 00000064 0
3 00000051 00000009 00000000 1a 00000009 0
2 00000007 00000006 00000064 1b 0000008e 0
0 00000001 00000002 00000000 1c 00000003 0
1 00000100 00000100 00000000 1d 00010000 0
0 0000000a 00000014 00000000 1e 0000001e 0
3 80000000 00000002 00000000 1f 40000000 0
1 00000011 00000011 00000000 20 00000121 0
2 00000002 00000002 00000002 21 00000006 0
0 fffffffe 00000003 00000000 22 00000001 0
3 00000009 00000003 00000000 23 00000003 1
1 00000007 00000007 00000000 24 00000031 0

// ==== tb/tb_apu_subsys.sv ====
/*
 * APU subsystem testbench
 * Runs instruction patterns from a data file through the DUT, checks results
 * in acceptance order, class and divider stalls, dependencies and activity
 */

`timescale 1ns/100ps

module tb_apu_subsys;

  import apu_cfg_pkg::*;
  import apu_op_pkg::*;

  localparam int NUM_PAT   = 36;
  localparam int PAT_W     = 7;
  localparam int WAIT_MAX  = 4 * DIV_STEPS;

  logic              clk_i;
  logic              rst_ni;
  logic              enable_r;
  apu_op_t           op_r;
  apu_word_t         a_r;
  apu_word_t         b_r;
  apu_word_t         c_r;
  apu_addr_t         waddr_r;
  apu_word_t         exp_r;
  logic              first_cycle;
  apu_addr_t [2:0]   read_regs_r;
  logic [2:0]        read_valid_r;
  apu_addr_t [1:0]   write_regs_r;
  logic [1:0]        write_valid_r;
  logic              valid_o;
  apu_addr_t         waddr_o;
  apu_word_t         result_o;
  logic              multicycle_o;
  logic              active_o;
  logic              stall_o;
  logic              read_dep_o;
  logic              write_dep_o;
  logic              perf_type_o;
  logic              perf_cont_o;

  logic [31:0]       pat_mem [NUM_PAT*PAT_W];
  // Expected entries, {waddr, result}
  logic [37:0]       exp_q [$];
  logic [37:0]       entry;
  apu_lat_t          last_lat;
  apu_lat_t          lat_new;
  logic              exp_type;
  int                since_accept;
  int                val_errs;
  int                other_errs;

  apu_subsys_top UUT (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .enable_i           (enable_r),
    .op_i               (op_r),
    .a_i                (a_r),
    .b_i                (b_r),
    .c_i                (c_r),
    .waddr_i            (waddr_r),
    .valid_o            (valid_o),
    .waddr_o            (waddr_o),
    .result_o           (result_o),
    .multicycle_o       (multicycle_o),
    .active_o           (active_o),
    .stall_o            (stall_o),
    .read_regs_i        (read_regs_r),
    .read_regs_valid_i  (read_valid_r),
    .read_dep_o         (read_dep_o),
    .write_regs_i       (write_regs_r),
    .write_regs_valid_i (write_valid_r),
    .write_dep_o        (write_dep_o),
    .perf_type_o        (perf_type_o),
    .perf_cont_o        (perf_cont_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checking helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
      val_errs++;
    end
  endtask

  task automatic report_counts();
    $display("Errors: %0d value mismatches, %0d other", val_errs, other_errs);
  endtask

  // Run cannot continue, end it here
  task automatic abort_run(input string why);
    $display("ERROR: %s", why);
    other_errs++;
    report_counts();
    $display("TB FAILED");
    $finish;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Monitor, scoreboard and stall model, all sampled mid cycle
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (rst_ni) begin
      // Only multicycle entries stay queued across a cycle
      check_val("active_o", active_o, exp_q.size() != 0);

      if (enable_r && first_cycle) begin
        lat_new  = op_latency(op_r);
        exp_type = (exp_q.size() != 0) &&
                   (lat_new == LAT_PIPE1 || apu_lat_t'(last_lat - lat_new) == 2'd1 ||
                    lat_new == LAT_ITER);
        if (lat_new != LAT_COMB) begin
          check_val("perf_type_o", perf_type_o, exp_type);
        end
        if (exp_type) begin
          check_val("stall_o", stall_o, 1);
        end
        check_val("multicycle_o", multicycle_o, last_lat == LAT_ITER);
        // Add behind a running divider sees the grant refused
        if (lat_new == LAT_COMB && last_lat == LAT_ITER && exp_q.size() != 0 &&
            since_accept < DIV_STEPS) begin
          check_val("stall_o", stall_o, 1);
          check_val("perf_cont_o", perf_cont_o, 1);
        end
      end

      if (enable_r && !stall_o) begin
        exp_q.push_back({waddr_r, exp_r});
        last_lat     = op_latency(op_r);
        since_accept = 0;
      end else begin
        since_accept++;
      end

      if (valid_o) begin
        if (exp_q.size() == 0) begin
          $display("ERROR: valid_o pulsed with no instruction pending");
          other_errs++;
        end else begin
          entry = exp_q.pop_front();
          check_val("waddr_o", waddr_o, entry[37:32]);
          check_val("result_o", result_o, entry[31:0]);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////////////////////////////////////////

  task automatic present(input apu_op_t op, input apu_word_t a, input apu_word_t b,
                         input apu_word_t c, input apu_addr_t waddr,
                         input apu_word_t exp);
    @(posedge clk_i);
    enable_r    <= 1'b1;
    op_r        <= op;
    a_r         <= a;
    b_r         <= b;
    c_r         <= c;
    waddr_r     <= waddr;
    exp_r       <= exp;
    first_cycle <= 1'b1;
  endtask

  // Hold the instruction until an edge with stall_o low, then idle for gap
  task automatic issue(input apu_op_t op, input apu_word_t a, input apu_word_t b,
                       input apu_word_t c, input apu_addr_t waddr,
                       input apu_word_t exp, input int gap);
    int  cnt;
    logic done;
    cnt  = 0;
    done = 1'b0;
    present(op, a, b, c, waddr, exp);
    while (!done) begin
      @(negedge clk_i);
      if (!stall_o) begin
        done = 1'b1;
      end else begin
        cnt++;
        if (cnt > WAIT_MAX) begin
          abort_run("instruction never accepted, stall_o stuck high");
        end
        @(posedge clk_i);
        first_cycle <= 1'b0;
      end
    end
    if (gap > 0) begin
      @(posedge clk_i);
      enable_r    <= 1'b0;
      first_cycle <= 1'b0;
      repeat (gap - 1) @(posedge clk_i);
    end
  endtask

  task automatic idle_and_drain();
    int cnt;
    cnt = 0;
    @(posedge clk_i);
    enable_r    <= 1'b0;
    first_cycle <= 1'b0;
    while (exp_q.size() != 0) begin
      cnt++;
      if (cnt > WAIT_MAX) begin
        abort_run("results never returned, queue did not drain");
      end
      @(posedge clk_i);
    end
    @(negedge clk_i);
    check_val("active_o", active_o, 0);
  endtask

  // MULADD to 0x2a, deps checked in its grant cycle and while in flight
  task automatic dep_case(input logic [2:0] rvalid, input logic [1:0] wvalid,
                          input logic expect_dep);
    present(OP_MULADD, 32'd3, 32'd4, 32'd5, 6'h2a, 32'd17);
    read_regs_r   <= {6'h15, 6'h2a, 6'h03};
    write_regs_r  <= {6'h2a, 6'h15};
    read_valid_r  <= rvalid;
    write_valid_r <= wvalid;
    @(negedge clk_i);
    check_val("stall_o", stall_o, 0);
    check_val("read_dep_o", read_dep_o, expect_dep);
    check_val("write_dep_o", write_dep_o, expect_dep);
    @(posedge clk_i);
    enable_r    <= 1'b0;
    first_cycle <= 1'b0;
    @(negedge clk_i);
    check_val("active_o", active_o, 1);
    check_val("read_dep_o", read_dep_o, expect_dep);
    check_val("write_dep_o", write_dep_o, expect_dep);
    idle_and_drain();
    @(posedge clk_i);
    read_valid_r  <= '0;
    write_valid_r <= '0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_ni        = 1'b0;
    enable_r      = 1'b0;
    op_r          = OP_ADD;
    a_r           = '0;
    b_r           = '0;
    c_r           = '0;
    waddr_r       = '0;
    exp_r         = '0;
    first_cycle   = 1'b0;
    read_regs_r   = '0;
    read_valid_r  = '0;
    write_regs_r  = '0;
    write_valid_r = '0;
    last_lat      = LAT_COMB;
    since_accept  = 0;
    val_errs      = 0;
    other_errs    = 0;
    $readmemh("tb/apu_patterns.txt", pat_mem);

    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;

    for (int i = 0; i < NUM_PAT; i++) begin
      issue(apu_op_t'(pat_mem[i*PAT_W][1:0]), pat_mem[i*PAT_W+1], pat_mem[i*PAT_W+2],
            pat_mem[i*PAT_W+3], pat_mem[i*PAT_W+4][APU_AW-1:0], pat_mem[i*PAT_W+5],
            pat_mem[i*PAT_W+6]);
    end
    idle_and_drain();

    // Unrelated or invalid registers, then matching ones
    dep_case(3'b101, 2'b01, 1'b0);
    dep_case(3'b010, 2'b10, 1'b1);
    repeat (3) @(posedge clk_i);

    report_counts();
    if (val_errs == 0 && other_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
